//--- filelist.f
rtl/lsu_pkg.sv
rtl/mem_op_decode.sv
rtl/apb_mem_master.sv
rtl/dmem_apb.sv
rtl/mem_wb_regs.sv
rtl/wb_align.sv
rtl/lsu_top.sv
tests/tb_lsu_top.sv

//--- Makefile
# Verilator build and run for the LSU testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '^PASS: all tests$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_lsu_top.sv
module tb_lsu_top;
	timeunit 1ns;
	timeprecision 100ps;
	import lsu_pkg::*;

	localparam int DEPTH       = 256;
	localparam int WAIT_STATES = 2;
	localparam int CLK_PERIOD  = 20;

	typedef struct packed {
		mem_op_e               op;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       addr;      // alu value or byte address
		logic [XLEN-1:0]       wdata;
		logic [XLEN-1:0]       exp_data;
		logic                  exp_err;
		logic [REG_ADDR_W-1:0] exp_rd;
		logic                  check_data;
		logic                  chain;     // keep valid high into the next entry
	} entry_t;

	logic                  clk;
	logic                  rst_n;
	logic                  req_valid_i;
	logic                  req_ready_o;
	mem_req_t              req_i;
	logic                  wb_valid_o;
	logic [REG_ADDR_W-1:0] wb_rd_o;
	logic [XLEN-1:0]       wb_data_o;
	logic                  wb_err_o;

	entry_t     tbl[$];
	logic [7:0] ref_mem [DEPTH*8];  // byte model of dmem
	int         exp_idx = 0;        // next table entry expected on writeback
	logic       built   = 1'b0;
	entry_t     mon_e;

	lsu_top #(
		.DEPTH       (DEPTH),
		.WAIT_STATES (WAIT_STATES)
	) dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_i       (req_i),
		.wb_valid_o  (wb_valid_o),
		.wb_rd_o     (wb_rd_o),
		.wb_data_o   (wb_data_o),
		.wb_err_o    (wb_err_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	function automatic int op_bytes(input mem_op_e op);
		case (op)
			OP_LB, OP_LBU, OP_SB: return 1;
			OP_LH, OP_LHU, OP_SH: return 2;
			OP_LW, OP_LWU, OP_SW: return 4;
			default:              return 8;
		endcase
	endfunction

	// keep the low n bytes, fill above from the top kept bit or with zeros
	function automatic logic [63:0] extend(input logic [63:0] raw, input int n, input logic sgn);
		logic [63:0] mask;
		mask = (n == 8) ? '1 : ((64'd1 << (8 * n)) - 64'd1);
		if (sgn && raw[8*n-1]) return raw | ~mask;
		return raw & mask;
	endfunction

	task automatic add_entry(input mem_op_e op, input logic [4:0] rd, input logic [63:0] addr,
	                         input logic [63:0] wdata, input logic chain);
		entry_t      e;
		int          n;
		int          base;
		logic        ld;
		logic        st;
		logic        err;
		logic [63:0] raw;
		n    = op_bytes(op);
		ld   = op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
		st   = op inside {OP_SB, OP_SH, OP_SW, OP_SD};
		err  = (ld || st) && (((addr % n) != 0) || ((addr >> 3) >= DEPTH));
		base = int'(addr[15:0]);
		raw  = '0;
		if (ld && !err) begin
			for (int i = n - 1; i >= 0; i--) raw = {raw[55:0], ref_mem[base+i]};
		end
		if (st && !err) begin
			for (int i = 0; i < n; i++) ref_mem[base+i] = wdata[8*i +: 8];
		end
		e.op         = op;
		e.rd         = rd;
		e.addr       = addr;
		e.wdata      = wdata;
		e.exp_data   = ld ? extend(raw, n, op inside {OP_LB, OP_LH, OP_LW, OP_LD}) : addr;
		e.exp_err    = err;
		e.exp_rd     = (st || err) ? '0 : rd;  // stores and faults leave rd alone
		e.check_data = !err && !st;
		e.chain      = chain;
		tbl.push_back(e);
	endtask

	task automatic build_table();
		add_entry(OP_ALU, 5'd1, 64'hdead_beef_0123_4567, '0, 1'b0);
		add_entry(OP_ALU, 5'd31, 64'h8000_0000_0000_0001, '0, 1'b0);
		for (int w = 0; w < 8; w++) begin
			add_entry(OP_SD, 5'd2, 64'(w * 8), {$urandom, $urandom}, 1'b1);  // random fill
		end
		add_entry(OP_SD, 5'd3, 64'h40, 64'h80f1_7f02_ff01_81fe, 1'b0);
		add_entry(OP_LD, 5'd4, 64'h40, '0, 1'b0);
		add_entry(OP_LD, 5'd5, 64'h38, '0, 1'b0);
		// partial stores into filled words
		add_entry(OP_SB, 5'd6, 64'h08, 64'h80, 1'b0);
		add_entry(OP_SB, 5'd6, 64'h0f, 64'h7f, 1'b0);
		add_entry(OP_SH, 5'd6, 64'h0a, 64'h8001, 1'b0);
		add_entry(OP_SW, 5'd6, 64'h14, 64'h8000_0000, 1'b0);
		add_entry(OP_SH, 5'd6, 64'h1e, 64'hffff_7fff, 1'b0);  // upper bits must be dropped
		add_entry(OP_LD, 5'd7, 64'h08, '0, 1'b0);
		add_entry(OP_LD, 5'd7, 64'h10, '0, 1'b0);
		add_entry(OP_LD, 5'd7, 64'h18, '0, 1'b0);
		for (int off = 0; off < 8; off++) begin
			add_entry(OP_LB, 5'd8, 64'(64'h40 + off), '0, 1'b0);
			add_entry(OP_LBU, 5'd9, 64'(64'h40 + off), '0, 1'b0);
		end
		for (int off = 0; off < 8; off += 2) begin
			add_entry(OP_LH, 5'd8, 64'(64'h08 + off), '0, 1'b0);
			add_entry(OP_LHU, 5'd9, 64'(64'h08 + off), '0, 1'b0);
		end
		for (int off = 0; off < 8; off += 4) begin
			add_entry(OP_LW, 5'd8, 64'(64'h10 + off), '0, 1'b0);
			add_entry(OP_LWU, 5'd9, 64'(64'h10 + off), '0, 1'b0);
		end
		// faults, then make sure word 4 is untouched
		add_entry(OP_LH, 5'd10, 64'h21, '0, 1'b0);
		add_entry(OP_SW, 5'd10, 64'h22, 64'hffff_ffff, 1'b0);
		add_entry(OP_SD, 5'd10, 64'h800, 64'h1234_5678_9abc_def0, 1'b0);
		add_entry(OP_LD, 5'd11, 64'h808, '0, 1'b0);
		add_entry(OP_SB, 5'd11, 64'hfff8, 64'h55, 1'b0);
		add_entry(OP_LD, 5'd12, 64'h20, '0, 1'b0);
		add_entry(OP_LD, 5'd12, 64'h00, '0, 1'b0);
		// back to back with valid held high
		add_entry(OP_ALU, 5'd13, 64'h0123_4567_89ab_cdef, '0, 1'b1);
		add_entry(OP_LD, 5'd14, 64'h40, '0, 1'b1);
		add_entry(OP_SB, 5'd15, 64'h41, 64'h5a, 1'b1);
		add_entry(OP_LBU, 5'd16, 64'h41, '0, 1'b1);
		add_entry(OP_ALU, 5'd17, 64'h1111, '0, 1'b1);
		add_entry(OP_ALU, 5'd18, 64'h2222, '0, 1'b1);
		add_entry(OP_LW, 5'd19, 64'h44, '0, 1'b1);
		add_entry(OP_LH, 5'd20, 64'h43, '0, 1'b1);
		add_entry(OP_LD, 5'd21, 64'h40, '0, 1'b0);
	endtask

	// writeback monitor, outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n && wb_valid_o) begin
			if (exp_idx >= tbl.size()) begin
				$display("ERROR: writeback at %0t with no request outstanding", $time);
				$display("FAIL: see errors above");
				$fatal(1, "unexpected writeback");
			end
			mon_e = tbl[exp_idx];
			compare($sformatf("entry %0d %s rd", exp_idx, mon_e.op.name()), 64'(wb_rd_o),
			        64'(mon_e.exp_rd));
			compare($sformatf("entry %0d %s err", exp_idx, mon_e.op.name()), 64'(wb_err_o),
			        64'(mon_e.exp_err));
			if (mon_e.check_data) begin
				compare($sformatf("entry %0d %s data", exp_idx, mon_e.op.name()), wb_data_o,
				        mon_e.exp_data);
			end
			exp_idx++;
		end
	end

	initial begin
		wait (built);
		#(tbl.size() * (8 + WAIT_STATES) * CLK_PERIOD + 100 * CLK_PERIOD);
		$display("ERROR: simulation timed out at %0t with %0d of %0d writebacks seen", $time,
		         exp_idx, tbl.size());
		$display("FAIL: see errors above");
		$fatal(1, "timeout");
	end

	initial begin
		rst_n       = 1'b0;
		req_valid_i = 1'b0;
		req_i       = '0;
		void'($urandom(32'h115c4924));
		build_table();
		built = 1'b1;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < tbl.size(); i++) begin
			req_valid_i   <= 1'b1;
			req_i.op      <= tbl[i].op;
			req_i.rd      <= tbl[i].rd;
			req_i.alu_res <= tbl[i].addr;
			req_i.wdata   <= tbl[i].wdata;
			@(negedge clk);
			while (!req_ready_o) @(negedge clk);
			@(posedge clk);  // handshake edge
			if (!tbl[i].chain) begin
				req_valid_i <= 1'b0;
				while (exp_idx < i + 1) @(posedge clk);
			end
		end
		req_valid_i <= 1'b0;
		while (exp_idx < tbl.size()) @(posedge clk);
		repeat (4) @(posedge clk);  // room for a stray extra writeback
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- rtl/lsu_top.sv
module lsu_top #(
	parameter int ADDR_W      = lsu_pkg::ADDR_W_DFLT,
	parameter int DEPTH       = 256,
	parameter int WAIT_STATES = 1
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           req_valid_i,
	output logic                           req_ready_o,
	input  lsu_pkg::mem_req_t              req_i,
	output logic                           wb_valid_o,
	output logic [lsu_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [lsu_pkg::XLEN-1:0]       wb_data_o,
	output logic                           wb_err_o
);
	import lsu_pkg::*;

	// internal apb bus
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [XLEN-1:0]   pwdata;
	logic [STRB_W-1:0] pstrb;
	logic [XLEN-1:0]   prdata;
	logic              pready;
	logic              pslverr;

	logic     rsp_valid;
	mem_rsp_t rsp;
	logic     wb_valid;
	mem_rsp_t wb_rsp;  // MEM/WB register contents

	apb_mem_master #(
		.ADDR_W (ADDR_W)
	) u_master (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_i       (req_i),
		.psel_o      (psel),
		.penable_o   (penable),
		.pwrite_o    (pwrite),
		.paddr_o     (paddr),
		.pwdata_o    (pwdata),
		.pstrb_o     (pstrb),
		.prdata_i    (prdata),
		.pready_i    (pready),
		.pslverr_i   (pslverr),
		.rsp_valid_o (rsp_valid),
		.rsp_o       (rsp)
	);

	dmem_apb #(
		.ADDR_W      (ADDR_W),
		.DEPTH       (DEPTH),
		.WAIT_STATES (WAIT_STATES)
	) u_dmem (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.pstrb_i   (pstrb),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	mem_wb_regs u_mem_wb (
		.clk         (clk),
		.rst_n       (rst_n),
		.rsp_valid_i (rsp_valid),
		.rsp_i       (rsp),
		.wb_valid_o  (wb_valid),
		.wb_rsp_o    (wb_rsp)
	);

	wb_align u_align (
		.valid_i    (wb_valid),
		.rsp_i      (wb_rsp),
		.wb_valid_o (wb_valid_o),
		.wb_rd_o    (wb_rd_o),
		.wb_data_o  (wb_data_o),
		.wb_err_o   (wb_err_o)
	);

endmodule

//--- rtl/wb_align.sv
module wb_align (
	input  logic                           valid_i,
	input  lsu_pkg::mem_rsp_t              rsp_i,
	output logic                           wb_valid_o,
	output logic [lsu_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [lsu_pkg::XLEN-1:0]       wb_data_o,
	output logic                           wb_err_o
);
	import lsu_pkg::*;

	logic [XLEN-1:0] shifted;  // addressed byte moved to bit 0
	logic [XLEN-1:0] loaded;

	always_comb begin
		shifted = rsp_i.data >> {rsp_i.byte_off, 3'b000};
		unique case (rsp_i.size)
			SZ_B: begin
				loaded = {{(XLEN-8){rsp_i.sign_ext && shifted[7]}}, shifted[7:0]};
			end
			SZ_H: begin
				loaded = {{(XLEN-16){rsp_i.sign_ext && shifted[15]}}, shifted[15:0]};
			end
			SZ_W: begin
				loaded = {{(XLEN-32){rsp_i.sign_ext && shifted[31]}}, shifted[31:0]};
			end
			default: begin
				loaded = shifted;  // full doubleword, offset is zero
			end
		endcase
	end

	assign wb_valid_o = valid_i;
	assign wb_data_o  = rsp_i.is_load ? loaded : rsp_i.data;
	assign wb_rd_o    = rsp_i.wen ? rsp_i.rd : '0;  // stores and faults show x0
	assign wb_err_o   = valid_i && rsp_i.err;

endmodule

//--- rtl/mem_wb_regs.sv
module mem_wb_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              rsp_valid_i,
	input  lsu_pkg::mem_rsp_t rsp_i,
	output logic              wb_valid_o,
	output lsu_pkg::mem_rsp_t wb_rsp_o
);
	import lsu_pkg::*;

	mem_rsp_t rsp_q;

	// valid is a one-cycle pulse per captured response
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= rsp_valid_i;
		end
	end

	// contents hold while execute is stalled on the bus
	always_ff @(posedge clk) begin
		if (rsp_valid_i) begin
			rsp_q     <= rsp_i;
			rsp_q.wen <= rsp_i.wen && !rsp_i.err;  // faulting ops never write rd
		end
	end

	assign wb_rsp_o = rsp_q;

endmodule

//--- rtl/dmem_apb.sv
module dmem_apb #(
	parameter int ADDR_W      = 16,
	parameter int DEPTH       = 256,
	parameter int WAIT_STATES = 1
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  logic [ADDR_W-1:0]          paddr_i,
	input  logic [lsu_pkg::XLEN-1:0]   pwdata_i,
	input  logic [lsu_pkg::STRB_W-1:0] pstrb_i,
	output logic [lsu_pkg::XLEN-1:0]   prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o
);
	import lsu_pkg::*;

	localparam int MEM_AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W  = $clog2(WAIT_STATES + 2);

	logic [XLEN-1:0]   mem [DEPTH];
	logic [31:0]       word_idx;
	logic [MEM_AW-1:0] mem_idx;
	logic              in_range;
	logic              access;
	logic [CNT_W-1:0]  wait_cnt;  // ACCESS cycles spent so far

	assign word_idx = 32'(paddr_i[ADDR_W-1:3]);
	assign mem_idx  = word_idx[MEM_AW-1:0];
	assign in_range = word_idx < 32'(DEPTH);

	assign access    = psel_i && penable_i;
	assign pready_o  = access && (wait_cnt == CNT_W'(WAIT_STATES));
	assign pslverr_o = pready_o && !in_range;
	assign prdata_o  = in_range ? mem[mem_idx] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (access && !pready_o) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else begin
			wait_cnt <= '0;
		end
	end

	// write lands on the completing cycle, out-of-range writes are dropped
	always_ff @(posedge clk) begin
		if (pready_o && pwrite_i && in_range) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (pstrb_i[i]) begin
					mem[mem_idx][8*i +: 8] <= pwdata_i[8*i +: 8];
				end
			end
		end
	end

	penable_psel_a: assert property (@(posedge clk) disable iff (!rst_n)
		penable_i |-> psel_i);

endmodule

//--- rtl/apb_mem_master.sv
module apb_mem_master #(
	parameter int ADDR_W = 16
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       req_valid_i,
	output logic                       req_ready_o,
	input  lsu_pkg::mem_req_t          req_i,
	output logic                       psel_o,
	output logic                       penable_o,
	output logic                       pwrite_o,
	output logic [ADDR_W-1:0]          paddr_o,
	output logic [lsu_pkg::XLEN-1:0]   pwdata_o,
	output logic [lsu_pkg::STRB_W-1:0] pstrb_o,
	input  logic [lsu_pkg::XLEN-1:0]   prdata_i,
	input  logic                       pready_i,
	input  logic                       pslverr_i,
	output logic                       rsp_valid_o,
	output lsu_pkg::mem_rsp_t          rsp_o
);
	import lsu_pkg::*;

	apb_state_e state_q;
	logic       init_done_q;   // keeps ready low in the first cycle after reset
	logic       quick_done_q;  // alu or misaligned op finishing
	mem_req_t   req_q;
	mem_ctrl_t  ctrl_d;
	mem_ctrl_t  ctrl_q;
	logic       accept;
	logic       needs_bus;
	logic       access_done;

	mem_op_decode u_decode (
		.op_i       (req_i.op),
		.addr_low_i (req_i.alu_res[2:0]),
		.ctrl_o     (ctrl_d)
	);

	assign req_ready_o = init_done_q && (state_q == ST_IDLE);
	assign accept      = req_valid_i && req_ready_o;
	assign needs_bus   = (ctrl_d.is_load || ctrl_d.is_store) && !ctrl_d.misaligned;
	assign access_done = (state_q == ST_ACCESS) && pready_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q      <= ST_IDLE;
			init_done_q  <= 1'b0;
			quick_done_q <= 1'b0;
		end else begin
			init_done_q  <= 1'b1;
			quick_done_q <= accept && !needs_bus;
			unique case (state_q)
				ST_IDLE: begin
					if (accept && needs_bus) begin
						state_q <= ST_SETUP;
					end
				end
				ST_SETUP: state_q <= ST_ACCESS;  // setup is always one cycle
				ST_ACCESS: begin
					if (pready_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q  <= req_i;
			ctrl_q <= ctrl_d;
		end
	end

	// bus fields come from the latched request, so they stay put until completion
	assign psel_o    = (state_q != ST_IDLE);
	assign penable_o = (state_q == ST_ACCESS);
	assign pwrite_o  = ctrl_q.is_store;
	assign paddr_o   = {req_q.alu_res[ADDR_W-1:3], 3'b000};
	assign pwdata_o  = req_q.wdata << {req_q.alu_res[2:0], 3'b000};  // into byte lanes
	assign pstrb_o   = ctrl_q.strb;

	assign rsp_valid_o = quick_done_q || access_done;

	always_comb begin
		rsp_o.wen      = !ctrl_q.is_store;
		rsp_o.rd       = req_q.rd;
		rsp_o.data     = ctrl_q.is_load ? prdata_i : req_q.alu_res;
		rsp_o.is_load  = ctrl_q.is_load;
		rsp_o.byte_off = req_q.alu_res[2:0];
		rsp_o.size     = ctrl_q.size;
		rsp_o.sign_ext = ctrl_q.sign_ext;
		rsp_o.err      = ctrl_q.misaligned || (access_done && pslverr_i);
	end

	apb_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
		psel_o && !access_done |=> $stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o));

	// a bus op drops ready until its response
	ready_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
		accept |=> !req_ready_o || rsp_valid_o);

endmodule

//--- rtl/mem_op_decode.sv
module mem_op_decode (
	input  lsu_pkg::mem_op_e   op_i,
	input  logic [2:0]         addr_low_i,
	output lsu_pkg::mem_ctrl_t ctrl_o
);
	import lsu_pkg::*;

	logic [STRB_W-1:0] size_mask;   // strobe pattern before shifting
	logic [2:0]        align_mask;  // low address bits that must be zero
	logic              mem_op;

	always_comb begin
		ctrl_o          = '0;
		ctrl_o.is_load  = op_i inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
		ctrl_o.is_store = op_i inside {OP_SB, OP_SH, OP_SW, OP_SD};
		ctrl_o.sign_ext = op_i inside {OP_LB, OP_LH, OP_LW, OP_LD};
		mem_op          = ctrl_o.is_load || ctrl_o.is_store;

		case (op_i)
			OP_LB, OP_LBU, OP_SB: ctrl_o.size = SZ_B;
			OP_LH, OP_LHU, OP_SH: ctrl_o.size = SZ_H;
			OP_LW, OP_LWU, OP_SW: ctrl_o.size = SZ_W;
			default:              ctrl_o.size = SZ_D;  // LD, SD and alu ops
		endcase

		unique case (ctrl_o.size)
			SZ_B: begin
				size_mask  = 8'h01;
				align_mask = 3'b000;
			end
			SZ_H: begin
				size_mask  = 8'h03;
				align_mask = 3'b001;
			end
			SZ_W: begin
				size_mask  = 8'h0f;
				align_mask = 3'b011;
			end
			default: begin
				size_mask  = 8'hff;
				align_mask = 3'b111;
			end
		endcase

		// alu ops never touch the bus
		if (mem_op) begin
			ctrl_o.strb       = size_mask << addr_low_i;
			ctrl_o.misaligned = |(addr_low_i & align_mask);
		end
	end

endmodule

//--- rtl/lsu_pkg.sv
package lsu_pkg;

	localparam int XLEN        = 64;
	localparam int STRB_W      = XLEN / 8;  // one strobe per byte lane
	localparam int REG_ADDR_W  = 5;
	localparam int ADDR_W_DFLT = 16;        // byte address into dmem

	// memory opcodes seen by the MEM stage
	typedef enum logic [3:0] {
		OP_ALU = 4'd0,
		OP_LB  = 4'd1,
		OP_LH  = 4'd2,
		OP_LW  = 4'd3,
		OP_LD  = 4'd4,
		OP_LBU = 4'd5,
		OP_LHU = 4'd6,
		OP_LWU = 4'd7,
		OP_SB  = 4'd8,
		OP_SH  = 4'd9,
		OP_SW  = 4'd10,
		OP_SD  = 4'd11
	} mem_op_e;

	typedef enum logic [1:0] {
		SZ_B = 2'd0,
		SZ_H = 2'd1,
		SZ_W = 2'd2,
		SZ_D = 2'd3
	} mem_size_e;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_SETUP  = 2'd1,
		ST_ACCESS = 2'd2
	} apb_state_e;

	typedef struct packed {
		mem_op_e               op;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       alu_res;  // alu value or effective address
		logic [XLEN-1:0]       wdata;
	} mem_req_t;

	typedef struct packed {
		logic              is_load;
		logic              is_store;
		mem_size_e         size;
		logic              sign_ext;
		logic [STRB_W-1:0] strb;
		logic              misaligned;
	} mem_ctrl_t;

	typedef struct packed {
		logic                  wen;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;     // alu value or raw memory word
		logic                  is_load;
		logic [2:0]            byte_off;
		mem_size_e             size;
		logic                  sign_ext;
		logic                  err;
	} mem_rsp_t;

endpackage
